/* all.f */
+incdir+include
src/neo_sdram_pkg.sv
src/rom_addr_decode.sv
src/sdram_read_sched.sv
src/rom_word_capture.sv
src/neo_rom_sdram.sv
test/tb_sdram_model.sv
test/tb_neo_rom_sdram.sv

/* Bender.yml */
package:
  name: neo_rom_sdram

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/neo_sdram_pkg.sv
      - src/rom_addr_decode.sv
      - src/sdram_read_sched.sv
      - src/rom_word_capture.sv
      - src/neo_rom_sdram.sv
      - target: test
        files:
          - test/tb_sdram_model.sv
          - test/tb_neo_rom_sdram.sv

/* test/tb_neo_rom_sdram.sv */
/*
 * Testbench for the ROM side of the SDRAM controller
 * Table driven downloads, single reads, priority and pending cases
 */
`timescale 1ns/1ps
`include "neo_sdram_defines.svh"

module tb_neo_rom_sdram;

	import neo_sdram_pkg::*;

	localparam int K_LOAD = 0;
	localparam int K_M68K = 1;
	localparam int K_SROM = 2;
	localparam int K_CROM = 3;
	localparam int K_ALL  = 4;
	localparam int K_LATE = 5;

	typedef struct packed
	{
		logic [2:0] kind;
		logic [7:0] idx;
		logic       wr;
		m68k_zone_t zone;
		logic [1:0] bank;
		logic       sfix;
	} row_t;

	logic clk_sys;
	logic nBNKB;
	logic load_active;
	logic [7:0] load_index;
	sdram_addr_t load_addr;
	logic load_wr;
	logic m68k_req;
	m68k_zone_t m68k_zone;
	logic [`NEO_M68K_AW:1] m68k_addr;
	logic [1:0] p_bank;
	logic crom_req;
	logic [23:0] c_latch;
	logic srom_req;
	logic [15:0] s_latch;
	logic fix_from_sfix;
	dout_t sdram_dout;
	logic sdram_ready_first;
	logic sdram_ready_fourth;
	logic sdram_rd;
	logic sdram_we;
	sdram_addr_t sdram_addr;
	prog_word_t m68k_data;
	logic m68k_valid;
	prog_word_t srom_data;
	logic srom_valid;
	sprite_word_t crom_data;
	logic crom_valid;

	row_t rows[$];
	int   cycles = 0;
	int   limit = 0;

	neo_rom_sdram neo_rom_sdram_inst (.*);

	tb_sdram_model tb_sdram_model_inst (
		.clk_sys            (clk_sys),
		.nBNKB              (nBNKB),
		.sdram_rd           (sdram_rd),
		.sdram_addr         (sdram_addr),
		.sdram_dout         (sdram_dout),
		.sdram_ready_first  (sdram_ready_first),
		.sdram_ready_fourth (sdram_ready_fourth)
	);

	// 100 ns clock
	initial
		clk_sys = 1'b0;
	always #50 clk_sys = ~clk_sys;

	// ============================================================
	// Reporting and compare tasks
	// ============================================================

	task automatic report_fail(input string what);
		$display("%s", what);
		$display("RESULT: FAIL");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_addr(input string name, input sdram_addr_t got, input sdram_addr_t exp);
		if (got !== exp)
			report_fail($sformatf("Error at %0t: %s = %h, expected %h", $time, name, got, exp));
	endtask

	task automatic check_prog(input string name, input prog_word_t got, input prog_word_t exp);
		if (got !== exp)
			report_fail($sformatf("Error at %0t: %s = %h, expected %h", $time, name, got, exp));
	endtask

	task automatic check_sprite(input string name, input sprite_word_t got,
		input sprite_word_t exp);
		if (got !== exp)
			report_fail($sformatf("Error at %0t: %s = %h, expected %h", $time, name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			report_fail($sformatf("Error at %0t: %s = %b, expected %b", $time, name, got, exp));
	endtask

	// Cycle budget, 40 per row plus reset
	always @(posedge clk_sys)
	begin
		cycles = cycles + 1;
		if (limit > 0 && cycles > limit)
			report_fail("Timeout: the run went past its cycle budget");
	end

	// ============================================================
	// Expected values from the address map
	// ============================================================

	function automatic sdram_addr_t load_expect(input logic [7:0] idx, input sdram_addr_t a);
		if (idx >= `NEO_IDX_CROMS)
			return 25'h1000000 + (sdram_addr_t'(idx[4:1]) << 19) + (sdram_addr_t'(idx[0]) << 1)
				+ (a << 1);
		case (idx)
			`NEO_IDX_SPROM: return a + `NEO_BASE_SYSROM;
			`NEO_IDX_SFIX:  return a + `NEO_BASE_SFIX;
			`NEO_IDX_P1A:   return a;
			`NEO_IDX_P1B:   return a + `NEO_BASE_P1B;
			`NEO_IDX_P2:    return a + `NEO_BASE_P2;
			`NEO_IDX_S1:    return a + `NEO_BASE_SROM;
			default:        return '0;
		endcase
	endfunction

	function automatic sdram_addr_t m68k_expect(input m68k_zone_t z,
		input logic [`NEO_M68K_AW:1] a, input logic [1:0] bank);
		case (z)
			zone_p1: return sdram_addr_t'(a[19:1]) * 2;
			zone_p2: return sdram_addr_t'((int'(bank) + 1) * 32'h100000) + sdram_addr_t'(a[19:1]) * 2;
			zone_sys: return `NEO_BASE_SYSROM + sdram_addr_t'(a[16:1]) * 2;
			default: return '0;
		endcase
	endfunction

	// Bit 3 of the latch lands inverted at byte offset bit 1
	function automatic sdram_addr_t srom_expect(input logic [15:0] s, input logic sfix);
		sdram_addr_t base;
		base = sfix ? `NEO_BASE_SFIX : `NEO_BASE_SROM;
		return base + sdram_addr_t'(s[15:4]) * 32 + sdram_addr_t'(s[2:0]) * 4 + (s[3] ? 0 : 2);
	endfunction

	function automatic sdram_addr_t crom_expect(input logic [23:0] c);
		return 25'h1000000 + sdram_addr_t'(c[20:0]) * 8;
	endfunction

	// Same fold as the memory model
	function automatic prog_word_t model_word(input sdram_addr_t a);
		return a[16:1] ^ {7'd0, a[24:16]};
	endfunction

	// ============================================================
	// Stimulus helpers
	// ============================================================

	task automatic add_row(input int kind, input int idx, input logic wr, input m68k_zone_t z,
		input int bank, input logic sfix);
		row_t r;
		r.kind = kind;
		r.idx  = idx;
		r.wr   = wr;
		r.zone = z;
		r.bank = bank;
		r.sfix = sfix;
		rows.push_back(r);
	endtask

	task automatic build_table();
		int load_idx [12] = '{0, 1, 2, 3, 4, 5, 6, 8, 9, 32, 33, 46};
		foreach (load_idx[i])
			add_row(K_LOAD, load_idx[i], 1'b1, zone_p1, 0, 1'b0);
		// Write enable low must stay low
		add_row(K_LOAD, 4, 1'b0, zone_p1, 0, 1'b0);
		add_row(K_LOAD, 32, 1'b0, zone_p1, 0, 1'b0);
		add_row(K_M68K, 0, 1'b0, zone_p1, 0, 1'b0);
		for (int b = 0; b < 4; b++)
			add_row(K_M68K, 0, 1'b0, zone_p2, b, 1'b0);
		add_row(K_M68K, 0, 1'b0, zone_sys, 0, 1'b0);
		add_row(K_SROM, 0, 1'b0, zone_p1, 0, 1'b0);
		add_row(K_SROM, 0, 1'b0, zone_p1, 0, 1'b1);
		add_row(K_CROM, 0, 1'b0, zone_p1, 0, 1'b0);
		add_row(K_CROM, 0, 1'b0, zone_p1, 0, 1'b0);
		add_row(K_ALL, 0, 1'b0, zone_sys, 2, 1'b1);
		add_row(K_LATE, 0, 1'b0, zone_p2, 1, 1'b0);
	endtask

	// Called 10 ns after a rising edge, strobes last one cycle
	task automatic pulse(input logic do_m, input logic do_c, input logic do_s);
		m68k_req = do_m;
		crom_req = do_c;
		srom_req = do_s;
		@(posedge clk_sys);
		#10;
		m68k_req = 1'b0;
		crom_req = 1'b0;
		srom_req = 1'b0;
	endtask

	// at_once: read must start the cycle after the strobe
	task automatic wait_read(input sdram_addr_t exp, input logic at_once);
		@(negedge clk_sys);
		if (at_once)
			check_bit("sdram_rd", sdram_rd, 1'b1);
		else
			while (!sdram_rd)
				@(negedge clk_sys);
		check_addr("sdram_addr", sdram_addr, exp);
	endtask

	task automatic wait_valid(input req_t who, input sdram_addr_t addr);
		prog_word_t w;
		w = model_word(addr);
		do
		begin
			@(negedge clk_sys);
			if (sdram_rd)
				report_fail("A second read started before the running one completed");
		end
		while (!(m68k_valid || srom_valid || crom_valid));
		if ({m68k_valid, srom_valid, crom_valid} !== {who == req_m68k, who == req_srom,
			who == req_crom})
			report_fail("Requests were served out of priority order");
		case (who)
			req_m68k: check_prog("m68k_data", m68k_data, w);
			req_srom: check_prog("srom_data", srom_data, w);
			default:  check_sprite("crom_data", crom_data, {4{w}});
		endcase
	endtask

	task automatic apply_row(input row_t r);
		sdram_addr_t exp_c;
		sdram_addr_t exp_s;
		sdram_addr_t exp_m;
		@(posedge clk_sys);
		#10;
		load_addr     = $urandom & 25'h007fffe;
		m68k_addr     = $urandom;
		c_latch       = $urandom;
		s_latch       = $urandom;
		m68k_zone     = r.zone;
		p_bank        = r.bank;
		fix_from_sfix = r.sfix;
		exp_c = crom_expect(c_latch);
		exp_s = srom_expect(s_latch, r.sfix);
		exp_m = m68k_expect(r.zone, m68k_addr, r.bank);
		case (r.kind)
			K_LOAD:
			begin
				load_active = 1'b1;
				load_index  = r.idx;
				load_wr     = r.wr;
				@(negedge clk_sys);
				check_addr("sdram_addr", sdram_addr, load_expect(r.idx, load_addr));
				check_bit("sdram_we", sdram_we,
					r.wr && (r.idx != `NEO_IDX_LOROM) && (r.idx != `NEO_IDX_M1));
				@(posedge clk_sys);
				#10;
				load_active = 1'b0;
				load_wr     = 1'b0;
			end
			K_M68K:
			begin
				pulse(1'b1, 1'b0, 1'b0);
				wait_read(exp_m, 1'b1);
				wait_valid(req_m68k, exp_m);
			end
			K_SROM:
			begin
				pulse(1'b0, 1'b0, 1'b1);
				wait_read(exp_s, 1'b1);
				wait_valid(req_srom, exp_s);
			end
			K_CROM:
			begin
				pulse(1'b0, 1'b1, 1'b0);
				wait_read(exp_c, 1'b1);
				wait_valid(req_crom, exp_c);
			end
			K_ALL:
			begin
				// Priority crom, then srom, then m68k
				pulse(1'b1, 1'b1, 1'b1);
				wait_read(exp_c, 1'b1);
				wait_valid(req_crom, exp_c);
				wait_read(exp_s, 1'b0);
				wait_valid(req_srom, exp_s);
				wait_read(exp_m, 1'b0);
				wait_valid(req_m68k, exp_m);
			end
			default:
			begin
				// m68k arrives while crom is running and waits
				pulse(1'b0, 1'b1, 1'b0);
				wait_read(exp_c, 1'b1);
				@(posedge clk_sys);
				#10;
				pulse(1'b1, 1'b0, 1'b0);
				wait_valid(req_crom, exp_c);
				wait_read(exp_m, 1'b0);
				wait_valid(req_m68k, exp_m);
			end
		endcase
	endtask

	// ============================================================
	// Main sequence
	// ============================================================

	initial
	begin
		void'($urandom(32'h94f0cf5a));
		nBNKB         = 1'b0;
		load_active   = 1'b0;
		load_index    = 8'd0;
		load_addr     = '0;
		load_wr       = 1'b0;
		m68k_req      = 1'b0;
		m68k_zone     = zone_p1;
		m68k_addr     = '0;
		p_bank        = 2'd0;
		crom_req      = 1'b0;
		c_latch       = '0;
		srom_req      = 1'b0;
		s_latch       = '0;
		fix_from_sfix = 1'b0;
		build_table();
		limit = 40 * rows.size() + 3;
		repeat (3) @(posedge clk_sys);
		#10;
		nBNKB = 1'b1;
		// Quiet outputs after reset
		@(negedge clk_sys);
		check_bit("sdram_rd", sdram_rd, 1'b0);
		check_bit("sdram_we", sdram_we, 1'b0);
		check_bit("m68k_valid", m68k_valid, 1'b0);
		check_bit("srom_valid", srom_valid, 1'b0);
		check_bit("crom_valid", crom_valid, 1'b0);
		foreach (rows[i])
			apply_row(rows[i]);
		$display("RESULT: PASS");
		$finish;
	end

endmodule

/* test/tb_sdram_model.sv */
/*
 * Behavioural SDRAM for the ROM read port
 * Answers each read with a word derived from the address,
 * first word after 4 cycles, C bursts end 3 cycles later
 */
`timescale 1ns/1ps

module tb_sdram_model
(
	input  logic                       clk_sys,
	input  logic                       nBNKB,
	input  logic                       sdram_rd,
	input  neo_sdram_pkg::sdram_addr_t sdram_addr,
	output neo_sdram_pkg::dout_t       sdram_dout,
	output logic                       sdram_ready_first,
	output logic                       sdram_ready_fourth
);

	import neo_sdram_pkg::*;

	logic        rd_seen;
	sdram_addr_t addr_seen;
	sdram_addr_t addr_q;
	logic        burst;
	logic        active;
	int          count;

	// Every address bit folds into the 16-bit word
	function automatic prog_word_t word_at(input sdram_addr_t a);
		return a[16:1] ^ {7'd0, a[24:16]};
	endfunction

	initial
	begin
		sdram_dout         = '0;
		sdram_ready_first  = 1'b0;
		sdram_ready_fourth = 1'b0;
		active             = 1'b0;
		burst              = 1'b0;
		count              = 0;
	end

	// Sample on the edge, answer 10 ns later like the stimulus
	always @(posedge clk_sys)
	begin
		rd_seen   = sdram_rd;
		addr_seen = sdram_addr;
		#10;
		sdram_ready_first  = 1'b0;
		sdram_ready_fourth = 1'b0;
		if (!nBNKB)
		begin
			active = 1'b0;
			count  = 0;
		end
		else if (rd_seen)
		begin
			// C area reads run the full four word burst
			addr_q = addr_seen;
			burst  = addr_seen[24];
			active = 1'b1;
			count  = 0;
		end
		else if (active)
		begin
			count = count + 1;
			if (count == 4)
			begin
				sdram_ready_first = 1'b1;
				sdram_dout        = {4{word_at(addr_q)}};
				if (!burst)
					active = 1'b0;
			end
			if (count == 7)
			begin
				sdram_ready_fourth = 1'b1;
				active             = 1'b0;
			end
		end
	end

endmodule

/* src/neo_rom_sdram.sv */
/*
 * ROM side of the console's SDRAM controller
 * 68k program, C and S fetches share one read port, romset
 * downloads write through the same address decode
 */
`timescale 1ns/1ps
`include "neo_sdram_defines.svh"

module neo_rom_sdram
(
	input  logic                        clk_sys,
	input  logic                        nBNKB,
	input  logic                        load_active,
	input  logic [7:0]                  load_index,
	input  neo_sdram_pkg::sdram_addr_t  load_addr,
	input  logic                        load_wr,
	input  logic                        m68k_req,
	input  neo_sdram_pkg::m68k_zone_t   m68k_zone,
	input  logic [`NEO_M68K_AW:1]       m68k_addr,
	input  logic [1:0]                  p_bank,
	input  logic                        crom_req,
	input  logic [23:0]                 c_latch,
	input  logic                        srom_req,
	input  logic [15:0]                 s_latch,
	input  logic                        fix_from_sfix,
	input  neo_sdram_pkg::dout_t        sdram_dout,
	input  logic                        sdram_ready_first,
	input  logic                        sdram_ready_fourth,
	output logic                        sdram_rd,
	output logic                        sdram_we,
	output neo_sdram_pkg::sdram_addr_t  sdram_addr,
	output neo_sdram_pkg::prog_word_t   m68k_data,
	output logic                        m68k_valid,
	output neo_sdram_pkg::prog_word_t   srom_data,
	output logic                        srom_valid,
	output neo_sdram_pkg::sprite_word_t crom_data,
	output logic                        crom_valid
);

	import neo_sdram_pkg::*;

	req_t grant;
	logic done_m68k;
	logic done_srom;
	logic done_crom;

	// Address map for downloads and granted reads
	rom_addr_decode rom_addr_decode_inst (
		.load_active   (load_active),
		.load_index    (load_index),
		.load_addr     (load_addr),
		.load_wr       (load_wr),
		.grant         (grant),
		.m68k_zone     (m68k_zone),
		.m68k_addr     (m68k_addr),
		.p_bank        (p_bank),
		.c_latch       (c_latch),
		.s_latch       (s_latch),
		.fix_from_sfix (fix_from_sfix),
		.sdram_addr    (sdram_addr),
		.sdram_we      (sdram_we)
	);

	// One read at a time, crom first
	sdram_read_sched sdram_read_sched_inst (
		.clk_sys            (clk_sys),
		.nBNKB              (nBNKB),
		.m68k_req           (m68k_req),
		.crom_req           (crom_req),
		.srom_req           (srom_req),
		.sdram_ready_first  (sdram_ready_first),
		.sdram_ready_fourth (sdram_ready_fourth),
		.sdram_rd           (sdram_rd),
		.grant              (grant),
		.done_m68k          (done_m68k),
		.done_srom          (done_srom),
		.done_crom          (done_crom)
	);

	// ============================================================
	// Result registers, one per requester
	// ============================================================

	rom_word_capture #(.payload_t(prog_word_t)) m68k_capture_inst (
		.clk_sys    (clk_sys),
		.nBNKB      (nBNKB),
		.done       (done_m68k),
		.sdram_dout (sdram_dout),
		.data       (m68k_data),
		.valid      (m68k_valid)
	);

	// Raw fix word, byte select stays with the video side
	rom_word_capture #(.payload_t(prog_word_t)) srom_capture_inst (
		.clk_sys    (clk_sys),
		.nBNKB      (nBNKB),
		.done       (done_srom),
		.sdram_dout (sdram_dout),
		.data       (srom_data),
		.valid      (srom_valid)
	);

	// Whole burst, both sprite halves
	rom_word_capture #(.payload_t(sprite_word_t)) crom_capture_inst (
		.clk_sys    (clk_sys),
		.nBNKB      (nBNKB),
		.done       (done_crom),
		.sdram_dout (sdram_dout),
		.data       (crom_data),
		.valid      (crom_valid)
	);

endmodule

/* src/rom_word_capture.sv */
/*
 * Result register for one requester
 * Takes the top lanes of the SDRAM read word on done and
 * pulses valid for one cycle
 */
`timescale 1ns/1ps

module rom_word_capture #(
	parameter type payload_t = logic [15:0]
)
(
	input  logic                 clk_sys,
	input  logic                 nBNKB,
	input  logic                 done,
	input  neo_sdram_pkg::dout_t sdram_dout,
	output payload_t             data,
	output logic                 valid
);

	// First word of the burst sits in the top lane
	localparam int DOUT_W = $bits(sdram_dout);
	localparam int PAY_W  = $bits(payload_t);

	// Valid follows done by one cycle
	always_ff @(posedge clk_sys or negedge nBNKB)
	begin
		if (!nBNKB)
			valid <= 1'b0;
		else
			valid <= done;
	end

	// Data held until the next read for this requester
	always_ff @(posedge clk_sys)
	begin
		if (done)
			data <= payload_t'(sdram_dout[DOUT_W-1 -: PAY_W]);
	end

	// Only one read in flight, so done never repeats back to back
	a_valid_single: assert property (@(posedge clk_sys) disable iff (!nBNKB)
		valid |=> !valid)
		else $error("valid held for two cycles");

endmodule

/* src/sdram_read_sched.sv */
/*
 * Fixed-priority read scheduler for the shared SDRAM port
 * One read in flight, priority crom > srom > m68k, strobes that
 * arrive while busy are held as pending
 */
`timescale 1ns/1ps

module sdram_read_sched
(
	input  logic                clk_sys,
	input  logic                nBNKB,
	input  logic                m68k_req,
	input  logic                crom_req,
	input  logic                srom_req,
	input  logic                sdram_ready_first,
	input  logic                sdram_ready_fourth,
	output logic                sdram_rd,
	output neo_sdram_pkg::req_t grant,
	output logic                done_m68k,
	output logic                done_srom,
	output logic                done_crom
);

	import neo_sdram_pkg::*;

	logic pend_m68k;
	logic pend_crom;
	logic pend_srom;
	logic want_m68k;
	logic want_crom;
	logic want_srom;
	logic busy;
	logic finish;
	req_t pick;

	// ============================================================
	// Arbitration
	// ============================================================

	assign busy = (grant != req_none);

	// Candidates when idle: anything pending plus fresh strobes
	assign want_m68k = pend_m68k | m68k_req;
	assign want_crom = pend_crom | crom_req;
	assign want_srom = pend_srom | srom_req;

	always_comb
	begin
		if (want_crom)
			pick = req_crom;
		else if (want_srom)
			pick = req_srom;
		else if (want_m68k)
			pick = req_m68k;
		else
			pick = req_none;
	end

	// Completion, C reads wait for the whole four word burst
	assign done_m68k = sdram_ready_first && (grant == req_m68k);
	assign done_srom = sdram_ready_first && (grant == req_srom);
	assign done_crom = sdram_ready_fourth && (grant == req_crom);
	assign finish    = done_m68k | done_srom | done_crom;

	// ============================================================
	// Grant and pending state
	// ============================================================

	always_ff @(posedge clk_sys or negedge nBNKB)
	begin
		if (!nBNKB)
		begin
			grant     <= req_none;
			sdram_rd  <= 1'b0;
			pend_m68k <= 1'b0;
			pend_crom <= 1'b0;
			pend_srom <= 1'b0;
		end
		else
		begin
			// Read strobe lasts one cycle
			sdram_rd <= 1'b0;
			if (busy)
			begin
				// Port taken, remember new strobes for later
				if (m68k_req)
					pend_m68k <= 1'b1;
				if (crom_req)
					pend_crom <= 1'b1;
				if (srom_req)
					pend_srom <= 1'b1;
				// Back to idle, next launch one cycle later
				if (finish)
					grant <= req_none;
			end
			else
			begin
				// Winner starts now, losers stay pending
				pend_m68k <= want_m68k && (pick != req_m68k);
				pend_crom <= want_crom && (pick != req_crom);
				pend_srom <= want_srom && (pick != req_srom);
				grant     <= pick;
				sdram_rd  <= (pick != req_none);
			end
		end
	end

	// ============================================================
	// Checks
	// ============================================================

	// Memory answers only reads that were issued
	a_ready_when_running: assert property (@(posedge clk_sys) disable iff (!nBNKB)
		(sdram_ready_first || sdram_ready_fourth) |-> busy)
		else $error("ready strobe with no read running");

	// Requesters wait for their valid before strobing again
	a_m68k_no_restrobe: assert property (@(posedge clk_sys) disable iff (!nBNKB)
		m68k_req |-> !pend_m68k && (grant != req_m68k))
		else $error("m68k strobe while its read is outstanding");

	a_crom_no_restrobe: assert property (@(posedge clk_sys) disable iff (!nBNKB)
		crom_req |-> !pend_crom && (grant != req_crom))
		else $error("crom strobe while its read is outstanding");

	a_srom_no_restrobe: assert property (@(posedge clk_sys) disable iff (!nBNKB)
		srom_req |-> !pend_srom && (grant != req_srom))
		else $error("srom strobe while its read is outstanding");

	// Address comes from the grant, so a read needs one
	a_rd_with_grant: assert property (@(posedge clk_sys) disable iff (!nBNKB)
		sdram_rd |-> busy)
		else $error("sdram_rd without a grant");

endmodule

/* src/rom_addr_decode.sv */
/*
 * SDRAM address decode for the ROM side
 * Download writes get a base offset per romset index, reads take
 * the address of the granted requester. Purely combinational
 */
`timescale 1ns/1ps
`include "neo_sdram_defines.svh"

module rom_addr_decode
(
	input  logic                       load_active,
	input  logic [7:0]                 load_index,
	input  neo_sdram_pkg::sdram_addr_t load_addr,
	input  logic                       load_wr,
	input  neo_sdram_pkg::req_t        grant,
	input  neo_sdram_pkg::m68k_zone_t  m68k_zone,
	input  logic [`NEO_M68K_AW:1]      m68k_addr,
	input  logic [1:0]                 p_bank,
	input  logic [23:0]                c_latch,
	input  logic [15:0]                s_latch,
	input  logic                       fix_from_sfix,
	output neo_sdram_pkg::sdram_addr_t sdram_addr,
	output logic                       sdram_we
);

	import neo_sdram_pkg::*;

	sdram_addr_t load_map;
	sdram_addr_t read_map;
	sdram_addr_t c_slot;
	sdram_addr_t s_base;
	sdram_addr_t p2_base;
	logic [2:0]  p2_slot;
	logic [16:0] s_offset;
	logic        load_to_bram;

	// ============================================================
	// Download path
	// ============================================================

	// C pairs: bit 24 marks the C area, index bits 4:1 pick a 512 KiB slot
	// and index bit 0 picks the odd or even word of the interleave
	assign c_slot = {1'b1, 1'b0, load_index[4:1], 17'h00000, load_index[0], 1'b0};

	always_comb
	begin
		load_map = '0;
		if (load_index >= `NEO_IDX_CROMS)
			load_map = {load_addr[`NEO_LOAD_AW-2:0], 1'b0} + c_slot;
		else
		begin
			case (load_index)
				`NEO_IDX_SPROM: load_map = load_addr + `NEO_BASE_SYSROM;
				`NEO_IDX_SFIX:  load_map = load_addr + `NEO_BASE_SFIX;
				`NEO_IDX_P1A:   load_map = load_addr;
				`NEO_IDX_P1B:   load_map = load_addr + `NEO_BASE_P1B;
				`NEO_IDX_P2:    load_map = load_addr + `NEO_BASE_P2;
				`NEO_IDX_S1:    load_map = load_addr + `NEO_BASE_SROM;
				// LO, M1 and unknown files land nowhere
				default:        load_map = '0;
			endcase
		end
	end

	// LO and M1 live in block RAM, never in SDRAM
	assign load_to_bram = (load_index == `NEO_IDX_LOROM) || (load_index == `NEO_IDX_M1);

	// ============================================================
	// Read path
	// ============================================================

	// Fix address, bit 3 inverted to swap the two column halves
	assign s_offset = {s_latch[15:4], s_latch[2:0], ~s_latch[3], 1'b0};
	assign s_base   = fix_from_sfix ? `NEO_BASE_SFIX : `NEO_BASE_SROM;

	// P2 banks start at 1 MiB, one bank per MiB
	assign p2_slot = {1'b0, p_bank} + 3'd1;
	assign p2_base = sdram_addr_t'(p2_slot) * `NEO_BASE_P2;

	always_comb
	begin
		read_map = '0;
		case (grant)
			// 8-byte bursts; extension bits above 20 fall outside 16 MiB
			req_crom: read_map = {1'b1, c_latch[20:0], 3'b000};
			req_srom: read_map = s_base + sdram_addr_t'(s_offset);
			req_m68k:
			begin
				case (m68k_zone)
					zone_p1:  read_map = {5'b0_0000, m68k_addr[19:1], 1'b0};
					zone_p2:  read_map = p2_base + {5'b0_0000, m68k_addr[19:1], 1'b0};
					zone_sys: read_map = `NEO_BASE_SYSROM + {8'h00, m68k_addr[16:1], 1'b0};
					default:  read_map = '0;
				endcase
			end
			default:  read_map = '0;
		endcase
	end

	// Download owns the port while it runs
	assign sdram_addr = load_active ? load_map : read_map;
	assign sdram_we   = load_active && !load_to_bram && load_wr;

	// Requesters are expected to stay quiet during a romset download
	always_comb
	begin
		a_no_grant_in_load: assert #0 (!(load_active && (grant != req_none)))
			else $error("read granted during download");
	end

endmodule

/* src/neo_sdram_pkg.sv */
/*
 * Types shared by the ROM read path of the SDRAM controller:
 * requester and zone codes, address and data words
 */
`include "neo_sdram_defines.svh"

package neo_sdram_pkg;

	// ============================================================
	// Requester served by the single SDRAM read port
	// ============================================================

	// req_none means the port is idle
	typedef enum logic [1:0]
	{
		req_none = 2'd0,
		req_m68k = 2'd1,
		req_crom = 2'd2,
		req_srom = 2'd3
	} req_t;

	// 68k ROM zone being fetched
	// Code 3 is unused and maps to address 0
	typedef enum logic [1:0]
	{
		zone_p1  = 2'd0,
		zone_p2  = 2'd1,
		zone_sys = 2'd2
	} m68k_zone_t;

	// ============================================================
	// Address and data words
	// ============================================================

	// Byte address, bit 0 stays 0 in word mode
	typedef logic [`NEO_SDRAM_AW-1:0] sdram_addr_t;

	// Program word for the 68k, also the raw fix word
	typedef logic [15:0] prog_word_t;

	// Two sprite bitplane pairs from one C burst
	typedef logic [63:0] sprite_word_t;

	// Raw read data, first word in the top lane
	typedef logic [`NEO_DOUT_W-1:0] dout_t;

endpackage

/* include/neo_sdram_defines.svh */
/*
 * ROM side of the SDRAM controller: shared widths, region bases
 * in the 32 MiB SDRAM map and romset download indexes
 */
`ifndef NEO_SDRAM_DEFINES_SVH
`define NEO_SDRAM_DEFINES_SVH

// ============================================================
// Widths
// ============================================================

// SDRAM byte address, 32 MiB
`define NEO_SDRAM_AW 25
// One read returns a four word burst
`define NEO_DOUT_W 64
// Download address from the loader
`define NEO_LOAD_AW 25
// 68k word address, bits 23:1
`define NEO_M68K_AW 23

// ============================================================
// Region bases (byte addresses)
// ============================================================

`define NEO_BASE_SYSROM 25'h0800000
`define NEO_BASE_SROM   25'h0820000
`define NEO_BASE_SFIX   25'h0880000
// Second half of P1 when it comes as two files
`define NEO_BASE_P1B    25'h0080000
// First 1 MiB P2 bank, later banks follow every 1 MiB
`define NEO_BASE_P2     25'h0100000

// ============================================================
// Download indexes
// ============================================================

`define NEO_IDX_SPROM 8'd0
`define NEO_IDX_LOROM 8'd1
`define NEO_IDX_SFIX  8'd2
`define NEO_IDX_P1A   8'd4
`define NEO_IDX_P1B   8'd5
`define NEO_IDX_P2    8'd6
`define NEO_IDX_S1    8'd8
`define NEO_IDX_M1    8'd9
// C files from here on, two per pair
`define NEO_IDX_CROMS 8'd32

`endif
